// ==== build.f ====
design/isa_pkg.sv
design/ctrl_pkg.sv
design/controller.sv
design/fetch_unit.sv
design/register_file.sv
design/execute_unit.sv
design/cpu_core.sv
dv/cpu_core_tb.sv

// ==== run.sh ====
#!/bin/sh
# build with verilator, run, and look for the pass line in the output
verilator --binary --timing --top-module cpu_core_tb -f build.f -o cpu_core_sim \
	&& ./obj_dir/cpu_core_sim | tee /dev/stderr | grep -qx "Test OK" \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

// ==== dv/cpu_core_tb.sv ====
`timescale 1ns/1ps

module cpu_core_tb;
	import isa_pkg::*;

	// movi constants after 20-bit sign extension
	localparam logic [31:0] c1 = 32'h0007_FFFF;
	localparam logic [31:0] c2 = 32'hFFF8_0123;
	localparam logic [31:0] c3 = 32'h0000_1234;
	localparam logic [31:0] c4 = 32'h0000_0100;

	logic        clock = 1'b0;
	logic        reset = 1'b1;
	logic [31:0] im_data = 32'h0;
	logic [31:0] dm_read_data = 32'h0;
	logic [31:0] im_address;
	logic        im_enable;
	logic        im_read;
	logic [31:0] dm_address;
	logic [31:0] dm_write_data;
	logic        dm_enable;
	logic        dm_read;
	logic        dm_write;

	logic [31:0] imem [64];
	logic [31:0] dmem [256];
	logic [31:0] seed_copy [256];
	logic [31:0] row_instr [64];
	logic        row_store [64];
	logic        row_load [64];
	logic [31:0] row_addr [64];
	logic [31:0] row_data [64];
	int          store_rows [$];
	int          n_rows = 0;
	int          hold_cycles = 2;
	int          cycle_count = 0;
	int          error_count = 0;
	int          check_count = 0;
	int          store_count = 0;
	int          store_index;
	int          last_fetch_cycle = 0;
	logic [31:0] last_fetch_address = 32'h0;
	logic        fetch_seen = 1'b0;
	logic        fetch_due;
	logic [5:0]  wb_row;
	logic        program_done = 1'b0;

	cpu_core #(
		.reset_address (32'h0000_0000)
	) u_dut (
		.clock         (clock),
		.reset         (reset),
		.im_data       (im_data),
		.dm_read_data  (dm_read_data),
		.im_address    (im_address),
		.im_enable     (im_enable),
		.im_read       (im_read),
		.dm_address    (dm_address),
		.dm_write_data (dm_write_data),
		.dm_enable     (dm_enable),
		.dm_read       (dm_read),
		.dm_write      (dm_write)
	);

	initial begin
		forever #5 clock = ~clock;
	end

	function automatic logic [31:0] alu_word(logic [4:0] rt, logic [4:0] ra, logic [4:0] rb,
		logic [4:0] sub);
		return {1'b0, ty_base, rt, ra, rb, 5'b0, sub};
	endfunction

	function automatic logic [31:0] imm_word(logic [5:0] op, logic [4:0] rt, logic [4:0] ra,
		logic [14:0] imm15);
		return {1'b0, op, rt, ra, imm15};
	endfunction

	function automatic logic [31:0] movi_word(logic [4:0] rt, logic [19:0] imm20);
		return {1'b0, op_movi, rt, imm20};
	endfunction

	function automatic logic [31:0] indexed_word(logic [4:0] rt, logic [4:0] ra, logic [4:0] rb,
		logic [1:0] sv, logic [7:0] sub);
		return {1'b0, ty_ls, rt, ra, rb, sv, sub};
	endfunction

	function automatic logic [31:0] seed_at(logic [31:0] addr);
		return seed_copy[addr[9:2]];
	endfunction

	task automatic plain_row(logic [31:0] instr);
		row_instr[n_rows[5:0]] = instr;
		row_store[n_rows[5:0]] = 1'b0;
		row_load[n_rows[5:0]] = 1'b0;
		n_rows++;
	endtask

	task automatic load_row(logic [31:0] instr);
		row_instr[n_rows[5:0]] = instr;
		row_store[n_rows[5:0]] = 1'b0;
		row_load[n_rows[5:0]] = 1'b1;
		n_rows++;
	endtask

	task automatic store_row(logic [31:0] instr, logic [31:0] addr, logic [31:0] data);
		row_instr[n_rows[5:0]] = instr;
		row_store[n_rows[5:0]] = 1'b1;
		row_load[n_rows[5:0]] = 1'b0;
		row_addr[n_rows[5:0]] = addr;
		row_data[n_rows[5:0]] = data;
		n_rows++;
	endtask

	task automatic check_value(string name, logic [31:0] got, logic [31:0] expected);
		check_count++;
		if (got !== expected) begin
			error_count++;
			$display("Mismatch at %0t: %s is %h, expected %h", $time, name, got, expected);
		end
	endtask

	task automatic build_program();
		plain_row(movi_word(5'd1, 20'h7_FFFF));
		plain_row(movi_word(5'd2, 20'h8_0123));
		plain_row(movi_word(5'd3, 20'h0_1234));
		plain_row(movi_word(5'd4, 20'h0_0100));
		store_row(imm_word(op_swi, 5'd1, 5'd0, 15'd1), 32'h04, c1);
		store_row(imm_word(op_swi, 5'd2, 5'd0, 15'd2), 32'h08, c2);
		store_row(imm_word(op_swi, 5'd3, 5'd4, 15'd3), c4 + 32'd12, c3);
		// negative word offset
		store_row(imm_word(op_swi, 5'd3, 5'd4, 15'h7FFF), c4 - 32'd4, c3);
		plain_row(alu_word(5'd5, 5'd2, 5'd3, sub_add));
		store_row(imm_word(op_swi, 5'd5, 5'd0, 15'd4), 32'h10, c2 + c3);
		plain_row(alu_word(5'd6, 5'd2, 5'd3, sub_sub));
		store_row(imm_word(op_swi, 5'd6, 5'd0, 15'd5), 32'h14, c2 - c3);
		plain_row(alu_word(5'd7, 5'd2, 5'd3, sub_and));
		store_row(imm_word(op_swi, 5'd7, 5'd0, 15'd6), 32'h18, c2 & c3);
		plain_row(alu_word(5'd8, 5'd2, 5'd3, sub_or));
		store_row(imm_word(op_swi, 5'd8, 5'd0, 15'd7), 32'h1C, c2 | c3);
		plain_row(alu_word(5'd9, 5'd2, 5'd3, sub_xor));
		store_row(imm_word(op_swi, 5'd9, 5'd0, 15'd8), 32'h20, c2 ^ c3);
		// immediate forms
		plain_row(imm_word(op_addi, 5'd10, 5'd3, 15'h7FFB));
		store_row(imm_word(op_swi, 5'd10, 5'd0, 15'd9), 32'h24, c3 - 32'd5);
		plain_row(imm_word(op_ori, 5'd11, 5'd2, 15'h6001));
		store_row(imm_word(op_swi, 5'd11, 5'd0, 15'd10), 32'h28, c2 | 32'h0000_6001);
		plain_row(imm_word(op_xori, 5'd12, 5'd2, 15'h7FFF));
		store_row(imm_word(op_swi, 5'd12, 5'd0, 15'd11), 32'h2C, c2 ^ 32'h0000_7FFF);
		plain_row(alu_word(5'd13, 5'd2, 5'd7, sub_srli));
		store_row(imm_word(op_swi, 5'd13, 5'd0, 15'd12), 32'h30, c2 >> 7);
		plain_row(alu_word(5'd14, 5'd1, 5'd9, sub_slli));
		store_row(imm_word(op_swi, 5'd14, 5'd0, 15'd13), 32'h34, c1 << 9);
		plain_row(alu_word(5'd15, 5'd2, 5'd12, sub_rotri));
		store_row(imm_word(op_swi, 5'd15, 5'd0, 15'd14), 32'h38, (c2 >> 12) | (c2 << 20));
		// loads from the seeded region at 0x200
		plain_row(movi_word(5'd16, 20'h0_0200));
		load_row(imm_word(op_lwi, 5'd17, 5'd16, 15'd5));
		store_row(imm_word(op_swi, 5'd17, 5'd0, 15'd15), 32'h3C, seed_at(32'h214));
		plain_row(movi_word(5'd18, 20'd8));
		load_row(indexed_word(5'd19, 5'd16, 5'd18, 2'd0, sub_lw));
		store_row(imm_word(op_swi, 5'd19, 5'd0, 15'd16), 32'h40, seed_at(32'h208));
		plain_row(movi_word(5'd20, 20'd6));
		load_row(indexed_word(5'd21, 5'd16, 5'd20, 2'd1, sub_lw));
		store_row(imm_word(op_swi, 5'd21, 5'd0, 15'd17), 32'h44, seed_at(32'h20C));
		plain_row(movi_word(5'd22, 20'd7));
		load_row(indexed_word(5'd23, 5'd16, 5'd22, 2'd2, sub_lw));
		store_row(imm_word(op_swi, 5'd23, 5'd0, 15'd18), 32'h48, seed_at(32'h21C));
		plain_row(movi_word(5'd24, 20'd3));
		load_row(indexed_word(5'd25, 5'd16, 5'd24, 2'd3, sub_lw));
		store_row(imm_word(op_swi, 5'd25, 5'd0, 15'd19), 32'h4C, seed_at(32'h218));
		// unknown codes must leave r5 and r6 alone
		plain_row(imm_word(6'b111111, 5'd5, 5'd2, 15'd0));
		plain_row(alu_word(5'd6, 5'd2, 5'd3, 5'b11111));
		store_row(imm_word(op_swi, 5'd5, 5'd0, 15'd20), 32'h50, c2 + c3);
		store_row(imm_word(op_swi, 5'd6, 5'd0, 15'd21), 32'h54, c2 - c3);
		// indexed store and its read back
		store_row(indexed_word(5'd9, 5'd4, 5'd20, 2'd3, sub_sw), c4 + 32'd48, c2 ^ c3);
		load_row(indexed_word(5'd26, 5'd4, 5'd20, 2'd3, sub_lw));
		store_row(imm_word(op_swi, 5'd26, 5'd0, 15'd22), 32'h58, c2 ^ c3);
	endtask

	// dut inputs change here while its outputs are stable
	always @(negedge clock) begin
		if (reset) begin
			hold_cycles--;
			if (hold_cycles == 0) begin
				reset = 1'b0;
			end
		end
		if (im_enable && im_read) begin
			im_data = imem[im_address[7:2]];
		end
		dm_read_data = dmem[dm_address[9:2]];
		if (!reset) begin
			cycle_count++;
			fetch_due = !fetch_seen || (cycle_count - last_fetch_cycle == 4);
			check_value("im_read", {31'b0, im_read}, {31'b0, fetch_due});
			if (fetch_seen && cycle_count - last_fetch_cycle == 3) begin
				wb_row = last_fetch_address[7:2];
				check_value("dm_read", {31'b0, dm_read}, {31'b0, row_load[wb_row]});
				check_value("dm_enable", {31'b0, dm_enable},
					{31'b0, row_load[wb_row] || row_store[wb_row]});
			end
			if (im_enable) begin
				if (fetch_seen) begin
					check_value("im_address", im_address, last_fetch_address + 32'd4);
					check_value("fetch spacing", cycle_count - last_fetch_cycle, 32'd4);
				end else begin
					check_value("im_address", im_address, 32'h0);
				end
				fetch_seen = 1'b1;
				last_fetch_cycle = cycle_count;
				last_fetch_address = im_address;
				if (im_address == n_rows * 4) begin
					program_done = 1'b1;
				end
			end
			if (dm_enable && !dm_write && store_count == 0) begin
				error_count++;
				$display("data memory enabled at %0t before the first store", $time);
			end
			if (dm_enable && dm_write) begin
				if (store_rows.size() == 0) begin
					error_count++;
					$display("unexpected store to %h at %0t", dm_address, $time);
				end else begin
					store_index = store_rows.pop_front();
					check_value("store row", last_fetch_address >> 2, store_index);
					check_value("store delay", cycle_count - last_fetch_cycle, 32'd3);
					check_value("dm_address", dm_address, row_addr[store_index[5:0]]);
					check_value("dm_write_data", dm_write_data, row_data[store_index[5:0]]);
				end
				dmem[dm_address[9:2]] = dm_write_data;
				store_count++;
			end
		end
	end

	initial begin
		wait (n_rows > 0 && cycle_count >= n_rows * 4 + 20);
		error_count++;
		$display("timeout: program did not finish after %0d cycles", cycle_count);
		$display("checks %0d, stores %0d, errors %0d", check_count, store_count, error_count);
		$display("Test FAILED");
		$finish;
	end

	initial begin
		void'($urandom(32'h496));
		for (int i = 0; i < 256; i++) begin
			dmem[i[7:0]] = $urandom;
			seed_copy[i[7:0]] = dmem[i[7:0]];
		end
		build_program();
		for (int i = 0; i < 64; i++) begin
			imem[i[5:0]] = 32'h0;
		end
		for (int i = 0; i < n_rows; i++) begin
			imem[i[5:0]] = row_instr[i[5:0]];
			if (row_store[i[5:0]]) begin
				store_rows.push_back(i);
			end
		end
		wait (program_done);
		if (store_rows.size() != 0) begin
			error_count++;
			$display("%0d expected stores never appeared", store_rows.size());
		end
		$display("checks %0d, stores %0d, errors %0d", check_count, store_count, error_count);
		if (error_count == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

// ==== design/cpu_core.sv ====
`timescale 1ns/1ps

module cpu_core #(
	parameter logic [31:0] reset_address = 32'h0000_0000
) (
	input  logic        clock,
	input  logic        reset,
	input  logic [31:0] im_data,
	input  logic [31:0] dm_read_data,
	output logic [31:0] im_address,
	output logic        im_enable,
	output logic        im_read,
	output logic [31:0] dm_address,
	output logic [31:0] dm_write_data,
	output logic        dm_enable,
	output logic        dm_read,
	output logic        dm_write
);
	import isa_pkg::*;

	instr_word_t instr;
	logic        pc_enable;
	logic        fetch_enable;
	logic        execute_enable;
	logic        writeback_enable;
	logic        reg_write;
	logic [1:0]  operand_sel;
	logic [1:0]  immediate_form;
	logic [1:0]  writeback_sel;
	logic [31:0] ra_data;
	logic [31:0] rb_data;
	logic [31:0] result;
	logic [31:0] imm_value;

	controller u_controller (
		.clock            (clock),
		.reset            (reset),
		.instr            (instr),
		.pc_enable        (pc_enable),
		.fetch_enable     (fetch_enable),
		.execute_enable   (execute_enable),
		.writeback_enable (writeback_enable),
		.reg_write        (reg_write),
		.im_enable        (im_enable),
		.im_read          (im_read),
		.dm_enable        (dm_enable),
		.dm_read          (dm_read),
		.dm_write         (dm_write),
		.operand_sel      (operand_sel),
		.immediate_form   (immediate_form),
		.writeback_sel    (writeback_sel)
	);

	fetch_unit #(
		.reset_address (reset_address)
	) u_fetch_unit (
		.clock        (clock),
		.reset        (reset),
		.pc_enable    (pc_enable),
		.fetch_enable (fetch_enable),
		.im_data      (im_data),
		.im_address   (im_address),
		.instr        (instr)
	);

	// rt_data goes straight out as the store data
	register_file u_register_file (
		.clock            (clock),
		.reset            (reset),
		.instr            (instr),
		.writeback_enable (writeback_enable),
		.reg_write        (reg_write),
		.writeback_sel    (writeback_sel),
		.result           (result),
		.imm_value        (imm_value),
		.dm_read_data     (dm_read_data),
		.ra_data          (ra_data),
		.rb_data          (rb_data),
		.rt_data          (dm_write_data)
	);

	execute_unit u_execute_unit (
		.clock          (clock),
		.reset          (reset),
		.instr          (instr),
		.execute_enable (execute_enable),
		.operand_sel    (operand_sel),
		.immediate_form (immediate_form),
		.ra_data        (ra_data),
		.rb_data        (rb_data),
		.result         (result),
		.imm_value      (imm_value)
	);

	assign dm_address = result;

endmodule

// ==== design/execute_unit.sv ====
`timescale 1ns/1ps

module execute_unit (
	input  logic                 clock,
	input  logic                 reset,
	input  isa_pkg::instr_word_t instr,
	input  logic                 execute_enable,
	input  logic [1:0]           operand_sel,
	input  logic [1:0]           immediate_form,
	input  logic [31:0]          ra_data,
	input  logic [31:0]          rb_data,
	output logic [31:0]          result,
	output logic [31:0]          imm_value
);
	import isa_pkg::*;
	import ctrl_pkg::*;

	logic [31:0] imm15_word;
	logic [31:0] operand_b;
	logic [4:0]  shamt;
	logic [63:0] rot_pair;
	logic [31:0] alu_out;

	always_comb begin
		case (immediate_form)
			imm5_unsigned:  imm_value = {27'b0, instr.base.rb_or_imm5};
			imm15_signed:   imm_value = {{17{instr.raw[14]}}, instr.raw[14:0]};
			imm15_unsigned: imm_value = {17'b0, instr.raw[14:0]};
			default:        imm_value = {{12{instr.raw[19]}}, instr.raw[19:0]};
		endcase
	end

	// word offset for lwi/swi
	assign imm15_word = {{15{instr.raw[14]}}, instr.raw[14:0], 2'b00};

	always_comb begin
		case (operand_sel)
			opnd_imm:      operand_b = imm_value;
			opnd_imm_word: operand_b = imm15_word;
			opnd_rb_scaled: operand_b = rb_data << instr.ls.sv;
			default:       operand_b = rb_data;
		endcase
	end

	assign shamt    = operand_b[4:0];
	assign rot_pair = {ra_data, ra_data} >> shamt;

	// address adds fall through to the default
	always_comb begin
		alu_out = ra_data + operand_b;
		case (instr.base.opcode)
			ty_base: begin
				case (instr.base.sub)
					sub_sub:   alu_out = ra_data - operand_b;
					sub_and:   alu_out = ra_data & operand_b;
					sub_or:    alu_out = ra_data | operand_b;
					sub_xor:   alu_out = ra_data ^ operand_b;
					sub_srli:  alu_out = ra_data >> shamt;
					sub_slli:  alu_out = ra_data << shamt;
					sub_rotri: alu_out = rot_pair[31:0];
					default:   alu_out = ra_data + operand_b;
				endcase
			end
			op_ori:  alu_out = ra_data | operand_b;
			op_xori: alu_out = ra_data ^ operand_b;
			default: alu_out = ra_data + operand_b;
		endcase
	end

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			result <= '0;
		end else if (execute_enable) begin
			result <= alu_out;
		end
	end

endmodule

// ==== design/register_file.sv ====
`timescale 1ns/1ps

module register_file (
	input  logic                 clock,
	input  logic                 reset,
	input  isa_pkg::instr_word_t instr,
	input  logic                 writeback_enable,
	input  logic                 reg_write,
	input  logic [1:0]           writeback_sel,
	input  logic [31:0]          result,
	input  logic [31:0]          imm_value,
	input  logic [31:0]          dm_read_data,
	output logic [31:0]          ra_data,
	output logic [31:0]          rb_data,
	output logic [31:0]          rt_data
);
	import ctrl_pkg::*;

	logic [31:0] regs [32];
	logic [31:0] write_data;

	always_comb begin
		case (writeback_sel)
			wb_imm:  write_data = imm_value;
			wb_mem:  write_data = dm_read_data;
			default: write_data = result;
		endcase
	end

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (writeback_enable && reg_write) begin
			regs[instr.ls.rt] <= write_data;
		end
	end

	assign ra_data = regs[instr.base.ra];
	assign rb_data = regs[instr.ls.rb];
	// store data
	assign rt_data = regs[instr.ls.rt];

endmodule

// ==== design/fetch_unit.sv ====
`timescale 1ns/1ps

module fetch_unit #(
	parameter logic [31:0] reset_address = 32'h0000_0000
) (
	input  logic                 clock,
	input  logic                 reset,
	input  logic                 pc_enable,
	input  logic                 fetch_enable,
	input  logic [31:0]          im_data,
	output logic [31:0]          im_address,
	output isa_pkg::instr_word_t instr
);

	logic [31:0] pc;

	// pc steps one word per fetch
	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			pc <= reset_address;
		end else if (pc_enable) begin
			pc <= pc + 32'd4;
		end
	end

	// instruction register, loaded the cycle after the memory read
	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			instr <= '0;
		end else if (fetch_enable) begin
			instr <= im_data;
		end
	end

	assign im_address = pc;

endmodule

// ==== design/controller.sv ====
`timescale 1ns/1ps

module controller (
	input  logic                clock,
	input  logic                reset,
	input  isa_pkg::instr_word_t instr,
	output logic                pc_enable,
	output logic                fetch_enable,
	output logic                execute_enable,
	output logic                writeback_enable,
	output logic                reg_write,
	output logic                im_enable,
	output logic                im_read,
	output logic                dm_enable,
	output logic                dm_read,
	output logic                dm_write,
	output logic [1:0]          operand_sel,
	output logic [1:0]          immediate_form,
	output logic [1:0]          writeback_sel
);
	import isa_pkg::*;
	import ctrl_pkg::*;

	state_t state;
	state_t next_state;

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			state <= st_fetch;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		case (state)
			st_fetch:   next_state = st_latch;
			st_latch:   next_state = st_execute;
			st_execute: next_state = st_writeback;
			default:    next_state = st_fetch;
		endcase
	end

	// phase strobes come from the state only
	assign pc_enable        = (state == st_fetch);
	assign im_enable        = (state == st_fetch);
	assign im_read          = (state == st_fetch);
	assign fetch_enable     = (state == st_latch);
	assign execute_enable   = (state == st_execute);
	assign writeback_enable = (state == st_writeback);
	assign dm_enable        = (state == st_writeback) && (dm_read || dm_write);

	// instruction decode
	always_comb begin
		operand_sel    = opnd_rb;
		immediate_form = imm5_unsigned;
		writeback_sel  = wb_alu;
		reg_write      = 1'b0;
		dm_read        = 1'b0;
		dm_write       = 1'b0;
		case (instr.base.opcode)
			ty_base: begin
				case (instr.base.sub)
					sub_add, sub_sub, sub_and, sub_or, sub_xor: begin
						reg_write = 1'b1;
					end
					sub_srli, sub_slli, sub_rotri: begin
						operand_sel = opnd_imm;
						reg_write   = 1'b1;
					end
					default: ;
				endcase
			end
			op_addi: begin
				operand_sel    = opnd_imm;
				immediate_form = imm15_signed;
				reg_write      = 1'b1;
			end
			op_ori, op_xori: begin
				operand_sel    = opnd_imm;
				immediate_form = imm15_unsigned;
				reg_write      = 1'b1;
			end
			op_movi: begin
				immediate_form = imm20_signed;
				writeback_sel  = wb_imm;
				reg_write      = 1'b1;
			end
			op_lwi: begin
				operand_sel    = opnd_imm_word;
				immediate_form = imm15_signed;
				writeback_sel  = wb_mem;
				reg_write      = 1'b1;
				dm_read        = 1'b1;
			end
			op_swi: begin
				operand_sel    = opnd_imm_word;
				immediate_form = imm15_signed;
				dm_write       = 1'b1;
			end
			ty_ls: begin
				case (instr.ls.sub)
					sub_lw: begin
						operand_sel   = opnd_rb_scaled;
						writeback_sel = wb_mem;
						reg_write     = 1'b1;
						dm_read       = 1'b1;
					end
					sub_sw: begin
						operand_sel = opnd_rb_scaled;
						dm_write    = 1'b1;
					end
					default: ;
				endcase
			end
			// unknown opcode, nothing written
			default: ;
		endcase
	end

endmodule

// ==== design/ctrl_pkg.sv ====
package ctrl_pkg;

	// one state per instruction phase
	typedef enum logic [1:0] {
		st_fetch     = 2'd0,
		st_latch     = 2'd1,
		st_execute   = 2'd2,
		st_writeback = 2'd3
	} state_t;

	// second alu operand
	localparam logic [1:0] opnd_rb        = 2'd0;
	localparam logic [1:0] opnd_imm       = 2'd1;
	localparam logic [1:0] opnd_imm_word  = 2'd2;
	localparam logic [1:0] opnd_rb_scaled = 2'd3;

	// register write source
	localparam logic [1:0] wb_alu = 2'd0;
	localparam logic [1:0] wb_imm = 2'd1;
	localparam logic [1:0] wb_mem = 2'd2;

endpackage

// ==== design/isa_pkg.sv ====
package isa_pkg;

	// major opcodes, bits 30 to 25
	localparam logic [5:0] ty_base = 6'b100000;
	localparam logic [5:0] ty_ls   = 6'b011100;
	localparam logic [5:0] op_addi = 6'b101000;
	localparam logic [5:0] op_ori  = 6'b101100;
	localparam logic [5:0] op_xori = 6'b101011;
	localparam logic [5:0] op_movi = 6'b100010;
	localparam logic [5:0] op_lwi  = 6'b000010;
	localparam logic [5:0] op_swi  = 6'b001010;

	// base-type sub-opcodes, bits 4 to 0
	localparam logic [4:0] sub_add   = 5'b00000;
	localparam logic [4:0] sub_sub   = 5'b00001;
	localparam logic [4:0] sub_and   = 5'b00010;
	localparam logic [4:0] sub_xor   = 5'b00011;
	localparam logic [4:0] sub_or    = 5'b00100;
	localparam logic [4:0] sub_slli  = 5'b01000;
	localparam logic [4:0] sub_srli  = 5'b01001;
	localparam logic [4:0] sub_rotri = 5'b01011;

	// load/store sub-opcodes, bits 7 to 0
	localparam logic [7:0] sub_lw = 8'b00000010;
	localparam logic [7:0] sub_sw = 8'b00001010;

	// immediate forms
	localparam logic [1:0] imm5_unsigned  = 2'd0;
	localparam logic [1:0] imm15_signed   = 2'd1;
	localparam logic [1:0] imm15_unsigned = 2'd2;
	localparam logic [1:0] imm20_signed   = 2'd3;

	// base view, also used for the immediate forms
	typedef struct packed {
		logic       spare_top;
		logic [5:0] opcode;
		logic [4:0] rt;
		logic [4:0] ra;
		logic [4:0] rb_or_imm5;
		logic [4:0] spare;
		logic [4:0] sub;
	} base_fields_t;

	// indexed load/store view
	typedef struct packed {
		logic       top;
		logic [5:0] opcode;
		logic [4:0] rt;
		logic [4:0] ra;
		logic [4:0] rb;
		logic [1:0] sv;
		logic [7:0] sub;
	} ls_fields_t;

	typedef union packed {
		base_fields_t base;
		ls_fields_t   ls;
		logic [31:0]  raw;
	} instr_word_t;

endpackage
